/* core_pkg.sv */
// core support package: shared vector types and menu status field positions
package core_pkg;

	// audio sample width, fixed for the whole design
	localparam int SAMPLE_W = 16;

	// menu status word and buttons
	typedef logic [63:0] status_t;
	typedef logic [1:0]  button_t;

	// joysticks, raw from the menu controller and trimmed for the core
	typedef logic [15:0] joy_raw_t;
	typedef logic [10:0] joy_t;

	// scanline strength, 0 to 75 %
	typedef logic [1:0] scanline_t;

	// one audio sample
	typedef logic [SAMPLE_W-1:0] sample_t;

	// reset sequencer counter
	typedef logic [27:0] reset_count_t;

	// phase accumulator and clock rates in Hz
	typedef logic [31:0] phase_t;

	// status word bit positions
	localparam int STATUS_RESET_BIT    = 0;
	localparam int STATUS_SCANLINE_LSB = 3;
	localparam int STATUS_BLEND_BIT    = 5;
	localparam int STATUS_JOYSWAP_BIT  = 6;
	localparam int STATUS_USERPORT_BIT = 7;
	localparam int STATUS_INVTAPE_BIT  = 8;

	// button bit positions
	localparam int BUTTON_RESET_BIT = 1;

endpackage

/* reset_seq.sv */
// reset sequencer: long power-on count and short restartable user-request count
`timescale 1ns/1ps

module reset_seq #(
	parameter core_pkg::reset_count_t POWER_ON_CYCLES   = 28'd268435455,
	parameter core_pkg::reset_count_t USER_RESET_CYCLES = 28'd65535
) (
	input  logic clk,
	input  logic pll_locked,
	input  logic menu_reset_req,
	input  logic core_reset_soft,
	input  logic core_reset_hard,
	output logic core_reset
);

	import core_pkg::*;

	reset_count_t count;
	logic         reset_req;

	// any source restarts the short count
	assign reset_req = menu_reset_req | core_reset_soft | core_reset_hard;

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			count      <= POWER_ON_CYCLES;
			core_reset <= 1'b1;
		end else begin
			if (reset_req) begin
				count <= USER_RESET_CYCLES;
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
			// registered from the old count, so one edge behind the counter
			core_reset <= (count != '0);
		end
	end

endmodule

/* user_controls.sv */
// user controls: menu option decode, joystick swap and user-port serial routing
`timescale 1ns/1ps

module user_controls (
	input  logic                 clk,
	input  logic                 pll_locked,
	input  core_pkg::status_t    status,
	input  core_pkg::button_t    buttons,
	input  core_pkg::joy_raw_t   joy0,
	input  core_pkg::joy_raw_t   joy1,
	input  logic                 uart_rx,
	input  logic                 core_uart_tx,
	input  logic                 downloading,
	output logic                 menu_reset_req,
	output core_pkg::scanline_t  scanlines,
	output logic                 blend,
	output core_pkg::joy_t       joy_left,
	output core_pkg::joy_t       joy_right,
	output logic                 core_uart_rx,
	output logic                 ear_in,
	output logic                 uart_tx,
	output logic                 led
);

	import core_pkg::*;

	logic joyswap;
	logic userport;
	logic invtape;
	logic rx_meta;
	logic rx_sync;

	// option fields
	assign menu_reset_req = status[STATUS_RESET_BIT] | buttons[BUTTON_RESET_BIT];
	assign scanlines      = status[STATUS_SCANLINE_LSB +: $bits(scanline_t)];
	assign blend          = status[STATUS_BLEND_BIT];
	assign joyswap        = status[STATUS_JOYSWAP_BIT];
	assign userport       = status[STATUS_USERPORT_BIT];
	assign invtape        = status[STATUS_INVTAPE_BIT];

	// joystick 1 is the left one unless swapped
	assign joy_left  = joyswap ? joy0[$bits(joy_t)-1:0] : joy1[$bits(joy_t)-1:0];
	assign joy_right = joyswap ? joy1[$bits(joy_t)-1:0] : joy0[$bits(joy_t)-1:0];

	// two-stage synchronizer, idles high like a uart line
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	// user port either feeds the core uart or acts as tape input
	assign core_uart_rx = userport ? rx_sync : 1'b0;
	assign ear_in       = userport ? 1'b0 : (invtape ^ rx_sync);
	assign uart_tx      = userport ? core_uart_tx : 1'b1;

	assign led = ~downloading;

endmodule

/* i2s_bit_enable.sv */
// I2S bit-clock enable: fractional phase accumulator spreading edges evenly
`timescale 1ns/1ps

module i2s_bit_enable #(
	parameter core_pkg::phase_t CLK_RATE    = 32'd27000000,
	parameter core_pkg::phase_t SAMPLE_RATE = 32'd48000
) (
	input  logic clk,
	input  logic pll_locked,
	input  logic core_reset,
	output logic bit_ce
);

	import core_pkg::*;

	// two bck edges per bit, two words per frame
	localparam phase_t STEP = phase_t'(SAMPLE_RATE * 4 * SAMPLE_W);

	phase_t acc;
	phase_t acc_next;

	assign acc_next = acc + STEP;

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			acc    <= '0;
			bit_ce <= 1'b0;
		end else if (core_reset) begin
			acc    <= '0;
			bit_ce <= 1'b0;
		end else begin
			bit_ce <= 1'b0;
			acc    <= acc_next;
			if (acc_next >= CLK_RATE) begin
				acc    <= acc_next - CLK_RATE;
				bit_ce <= 1'b1;
			end
		end
	end

endmodule

/* i2s_serializer.sv */
// I2S serializer: bit and word clocks, per-frame sample latch, Philips framing
`timescale 1ns/1ps

module i2s_serializer (
	input  logic              clk,
	input  logic              pll_locked,
	input  logic              core_reset,
	input  logic              bit_ce,
	input  core_pkg::sample_t audio_left,
	input  core_pkg::sample_t audio_right,
	output logic              i2s_bck,
	output logic              i2s_lrck,
	output logic              i2s_data
);

	import core_pkg::*;

	localparam int CNT_W = $clog2(SAMPLE_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SAMPLE_W - 1);

	logic [CNT_W-1:0] bit_idx;
	logic [CNT_W-1:0] bit_sel;
	sample_t          left_word;
	sample_t          right_word;

	// msb first within each word
	assign bit_sel = LAST_BIT - bit_idx;

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			bit_idx    <= '0;
			i2s_bck    <= 1'b1;
			i2s_lrck   <= 1'b1;
			i2s_data   <= 1'b1;
			left_word  <= '0;
			right_word <= '0;
		end else if (core_reset) begin
			bit_idx    <= '0;
			i2s_bck    <= 1'b1;
			i2s_lrck   <= 1'b1;
			i2s_data   <= 1'b1;
			left_word  <= '0;
			right_word <= '0;
		end else if (bit_ce) begin
			i2s_bck <= ~i2s_bck;
			// bck falling
			if (i2s_bck) begin
				if (bit_idx == LAST_BIT) begin
					bit_idx  <= '0;
					i2s_lrck <= ~i2s_lrck;
					// lrck falls, new frame starts with left
					if (i2s_lrck) begin
						left_word  <= audio_left;
						right_word <= audio_right;
					end
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
				// old lrck and old words give the one-bit delay
				i2s_data <= i2s_lrck ? right_word[bit_sel] : left_word[bit_sel];
			end
		end
	end

endmodule

/* core_top.sv */
// core support top level: reset sequencing, user controls and I2S audio output
`timescale 1ns/1ps

module core_top #(
	parameter core_pkg::phase_t       CLK_RATE          = 32'd27000000,
	parameter core_pkg::phase_t       SAMPLE_RATE       = 32'd48000,
	parameter core_pkg::reset_count_t POWER_ON_CYCLES   = 28'd268435455,
	parameter core_pkg::reset_count_t USER_RESET_CYCLES = 28'd65535
) (
	input  logic                clk,
	input  logic                pll_locked,

	// menu controller
	input  core_pkg::status_t   status,
	input  core_pkg::button_t   buttons,
	input  core_pkg::joy_raw_t  joy0,
	input  core_pkg::joy_raw_t  joy1,
	input  logic                downloading,

	// core side
	input  logic                core_reset_soft,
	input  logic                core_reset_hard,
	input  logic                core_uart_tx,
	input  core_pkg::sample_t   audio_left,
	input  core_pkg::sample_t   audio_right,
	output logic                core_reset,
	output core_pkg::scanline_t scanlines,
	output logic                blend,
	output core_pkg::joy_t      joy_left,
	output core_pkg::joy_t      joy_right,
	output logic                core_uart_rx,
	output logic                ear_in,

	// board pins
	input  logic                uart_rx,
	output logic                uart_tx,
	output logic                led,
	output logic                i2s_bck,
	output logic                i2s_lrck,
	output logic                i2s_data
);

	logic menu_reset_req;
	logic bit_ce;

	reset_seq #(
		.POWER_ON_CYCLES   (POWER_ON_CYCLES),
		.USER_RESET_CYCLES (USER_RESET_CYCLES)
	) u_reset_seq (
		.clk             (clk),
		.pll_locked      (pll_locked),
		.menu_reset_req  (menu_reset_req),
		.core_reset_soft (core_reset_soft),
		.core_reset_hard (core_reset_hard),
		.core_reset      (core_reset)
	);

	user_controls u_user_controls (
		.clk            (clk),
		.pll_locked     (pll_locked),
		.status         (status),
		.buttons        (buttons),
		.joy0           (joy0),
		.joy1           (joy1),
		.uart_rx        (uart_rx),
		.core_uart_tx   (core_uart_tx),
		.downloading    (downloading),
		.menu_reset_req (menu_reset_req),
		.scanlines      (scanlines),
		.blend          (blend),
		.joy_left       (joy_left),
		.joy_right      (joy_right),
		.core_uart_rx   (core_uart_rx),
		.ear_in         (ear_in),
		.uart_tx        (uart_tx),
		.led            (led)
	);

	// audio held in reset along with the core
	i2s_bit_enable #(
		.CLK_RATE    (CLK_RATE),
		.SAMPLE_RATE (SAMPLE_RATE)
	) u_i2s_bit_enable (
		.clk        (clk),
		.pll_locked (pll_locked),
		.core_reset (core_reset),
		.bit_ce     (bit_ce)
	);

	i2s_serializer u_i2s_serializer (
		.clk         (clk),
		.pll_locked  (pll_locked),
		.core_reset  (core_reset),
		.bit_ce      (bit_ce),
		.audio_left  (audio_left),
		.audio_right (audio_right),
		.i2s_bck     (i2s_bck),
		.i2s_lrck    (i2s_lrck),
		.i2s_data    (i2s_data)
	);

endmodule

/* tb_clock.sv */
// testbench clock source: 10 ns clock and pll lock released after a few cycles
`timescale 1ns/1ps

module tb_clock #(
	parameter int LOCK_CYCLES = 4
) (
	output logic clk,
	output logic pll_locked
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// lock rises 1 ns after an edge, away from the sampling point
	initial begin
		pll_locked = 1'b0;
		repeat (LOCK_CYCLES) @(posedge clk);
		#1 pll_locked = 1'b1;
	end

endmodule

/* tb_core_top.sv */
// core support testbench: random stimulus checked against reset, option and I2S models
`timescale 1ns/1ps

module tb_core_top;

	import core_pkg::*;

	localparam phase_t       CLK_RATE          = 32'd27000000;
	localparam phase_t       SAMPLE_RATE       = 32'd48000;
	localparam reset_count_t POWER_ON_CYCLES   = 28'd300;
	localparam reset_count_t USER_RESET_CYCLES = 28'd40;
	localparam int FRAMES      = 12;
	localparam int SPAN_CYCLES = 10 * int'(CLK_RATE) / int'(SAMPLE_RATE);
	// lock, power-on count, twelve frames of at most 563 cycles, plus the other tests
	localparam int TIMEOUT_CYCLES = 5 + int'(POWER_ON_CYCLES) + FRAMES * 563 + 2000;

	logic      clk, pll_locked;
	status_t   status = '0;
	button_t   buttons = '0;
	joy_raw_t  joy0 = '0, joy1 = '0;
	sample_t   audio_left = '0, audio_right = '0;
	logic      downloading = 1'b0, core_uart_tx = 1'b0, uart_rx = 1'b1;
	logic      core_reset_soft = 1'b0, core_reset_hard = 1'b0;
	logic      core_reset, blend, core_uart_rx, ear_in, uart_tx, led;
	scanline_t scanlines;
	joy_t      joy_left, joy_right;
	logic      i2s_bck, i2s_lrck, i2s_data;

	int      seed = 54786;
	int      cycle_count = 0;
	int      r, since, falls, rises, span_start, span;
	logic    req, rx_d1, rx_d2, userport, swap, prev_bck, prev_lrck;
	logic [2*SAMPLE_W-1:0] rx_shift;
	sample_t lat_l, lat_r, chk_l, chk_r;

	tb_clock u_tb_clock (.clk(clk), .pll_locked(pll_locked));

	core_top #(
		.CLK_RATE          (CLK_RATE),
		.SAMPLE_RATE       (SAMPLE_RATE),
		.POWER_ON_CYCLES   (POWER_ON_CYCLES),
		.USER_RESET_CYCLES (USER_RESET_CYCLES)
	) u_core_top (.*);

	task automatic fail_run();
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got, exp);
		$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
		fail_run();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic check_joy(input string name, input joy_t got, input joy_t exp);
		if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic check_scanlines(input string name, input scanline_t got, input scanline_t exp);
		if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d clock cycles", cycle_count);
			fail_run();
		end
	end

	initial begin
		// power-on count, i2s pins idle high meanwhile
		@(posedge pll_locked);
		for (int k = 1; k <= int'(POWER_ON_CYCLES) + 1; k++) begin
			@(posedge clk);
			#1;
			check_bit("core_reset", core_reset, k <= int'(POWER_ON_CYCLES));
			check_bit("i2s_bck", i2s_bck, 1'b1);
			check_bit("i2s_lrck", i2s_lrck, 1'b1);
			check_bit("i2s_data", i2s_data, 1'b1);
		end

		// random requests, options, joysticks and user port, then a quiet tail
		since = 1000;
		req = 1'b0;
		rx_d1 = 1'b1;
		for (int i = 0; i < 300; i++) begin
			@(posedge clk);
			#1;
			// high from the edge after a request until 41 edges after the last one
			since++;
			check_bit("core_reset", core_reset, since <= int'(USER_RESET_CYCLES));
			if (req) since = 0;
			r = $random(seed);
			req = (i < 240) && (r[2:0] == 3'd0);
			status = {$random(seed), $random(seed)};
			status[STATUS_RESET_BIT] = req && (r[4:3] == 2'd0);
			buttons = {req && (r[4:3] == 2'd1), r[5]};
			core_reset_soft = req && (r[4:3] == 2'd2);
			core_reset_hard = req && (r[4:3] == 2'd3);
			joy0 = joy_raw_t'($random(seed));
			joy1 = joy_raw_t'($random(seed));
			downloading = r[6];
			core_uart_tx = r[7];
			rx_d2 = rx_d1;
			rx_d1 = uart_rx;
			uart_rx = r[8];
			#2;
			userport = status[STATUS_USERPORT_BIT];
			swap = status[STATUS_JOYSWAP_BIT];
			check_scanlines("scanlines", scanlines, status[STATUS_SCANLINE_LSB +: 2]);
			check_bit("blend", blend, status[STATUS_BLEND_BIT]);
			check_joy("joy_left", joy_left, swap ? joy_t'(joy0) : joy_t'(joy1));
			check_joy("joy_right", joy_right, swap ? joy_t'(joy1) : joy_t'(joy0));
			check_bit("led", led, !downloading);
			check_bit("core_uart_rx", core_uart_rx, userport ? rx_d2 : 1'b0);
			check_bit("ear_in", ear_in, userport ? 1'b0 : rx_d2 ^ status[STATUS_INVTAPE_BIT]);
			check_bit("uart_tx", uart_tx, userport ? core_uart_tx : 1'b1);
		end

		// new stereo pair after each lrck fall, words collected on bck rises
		prev_bck = i2s_bck;
		prev_lrck = i2s_lrck;
		falls = 0;
		rises = 0;
		while (falls < FRAMES || rises == 0) begin
			@(posedge clk);
			#1;
			if (prev_lrck && !i2s_lrck) begin
				falls++;
				if (falls >= 2 && rises != 2 * SAMPLE_W) begin
					$display("frame before lrck fall %0d held %0d bck rises instead of %0d",
						falls, rises, 2 * SAMPLE_W);
					fail_run();
				end
				if (falls == 2) span_start = cycle_count;
				if (falls == FRAMES) begin
					span = cycle_count - span_start;
					if (span < SPAN_CYCLES - 2 || span > SPAN_CYCLES + 2) begin
						$display("ten frames took %0d clock cycles, expected %0d", span, SPAN_CYCLES);
						fail_run();
					end
				end
				rises = 0;
				chk_l = lat_l;
				chk_r = lat_r;
				lat_l = audio_left;
				lat_r = audio_right;
				audio_left = sample_t'($random(seed));
				audio_right = sample_t'($random(seed));
			end
			if (!prev_bck && i2s_bck) begin
				rx_shift = {rx_shift[2*SAMPLE_W-2:0], i2s_data};
				rises++;
				// right lsb arrives one rise after the next lrck fall
				if (rises == 1 && falls >= 3) begin
					check_sample("i2s_data left word", rx_shift[2*SAMPLE_W-1 -: SAMPLE_W], chk_l);
					check_sample("i2s_data right word", rx_shift[SAMPLE_W-1:0], chk_r);
				end
			end
			prev_bck = i2s_bck;
			prev_lrck = i2s_lrck;
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* all.f */
core_pkg.sv
reset_seq.sv
user_controls.sv
i2s_bit_enable.sv
i2s_serializer.sv
core_top.sv
tb_clock.sv
tb_core_top.sv

/* Makefile */
# Verilator lint, simulation and clean for the core support block

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_core_top
RTL_TOP    ?= core_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	./$(BUILD_DIR)/sim_$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
